//--- rtl/vision_pkg.sv
package vision_pkg;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////
	localparam int CHAN_W   = 8;
	localparam int COORD_W  = 12;
	localparam int TMDS_W   = 10;
	localparam int DISP_W   = 5;
	localparam int BAND_NUM = 4;	// classification bands, priority 0 first

	//////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////
	typedef logic [CHAN_W-1:0]          chan_t;		// one colour channel or threshold
	typedef logic [3*CHAN_W-1:0]        rgb_t;		// {r, g, b}, blue in the low byte
	typedef logic [COORD_W-1:0]         coord_t;	// column or row
	typedef logic [TMDS_W-1:0]          tmds_t;
	typedef logic signed [DISP_W-1:0]   disp_t;		// running dc balance

	//////////////////////////////////////////////////
	// class colours
	//////////////////////////////////////////////////
	localparam rgb_t COLOR_BAND0 = 24'h7F_00_00;	// dark red, the target band
	localparam rgb_t COLOR_BAND1 = 24'h00_FF_00;	// green
	localparam rgb_t COLOR_BAND2 = 24'h00_00_FF;	// blue
	localparam rgb_t COLOR_BAND3 = 24'hFF_FF_00;	// yellow
	localparam rgb_t COLOR_NONE  = 24'h00_00_00;
	localparam rgb_t COLOR_BOX   = 24'hFF_FF_FF;	// overlay border

	//////////////////////////////////////////////////
	// tmds symbols
	//////////////////////////////////////////////////
	// control tokens, index is {c1, c0}
	localparam tmds_t TMDS_CTRL_00 = 10'b1101010100;
	localparam tmds_t TMDS_CTRL_01 = 10'b0010101011;
	localparam tmds_t TMDS_CTRL_10 = 10'b0101010100;
	localparam tmds_t TMDS_CTRL_11 = 10'b1010101011;

	// clock lane, one pixel period per word
	localparam tmds_t TMDS_CLK_PATTERN = 10'b1111100000;

endpackage

//--- rtl/pixel_if.sv
`timescale 1ns/1ps

interface pixel_if;
	import vision_pkg::*;

	logic   vsync;		// high active
	logic   hsync;
	logic   de;
	rgb_t   data;
	coord_t x;			// column within the active line
	coord_t y;			// active line within the frame
	logic   hit;		// pixel falls in band 0

	// producer side
	modport src (output vsync, hsync, de, data, x, y, hit);

	// consumer side
	modport snk (input vsync, hsync, de, data, x, y, hit);

endinterface

//--- rtl/color_classifier.sv
`timescale 1ns/1ps

module color_classifier (
	input  logic                 pixel_clk_i,
	input  logic                 arst_n_i,
	input  logic                 vsync_i,
	input  logic                 hsync_i,
	input  logic                 de_i,
	input  logic                 mode_i,		// 0 pass, 1 classify
	input  vision_pkg::rgb_t     data_i,
	input  vision_pkg::chan_t    band_min_i [vision_pkg::BAND_NUM],
	input  vision_pkg::chan_t    band_max_i [vision_pkg::BAND_NUM],
	pixel_if.src                 out_o
);
	import vision_pkg::*;

	logic [BAND_NUM-1:0] band_hit;
	rgb_t                class_color;
	coord_t              x_cnt;
	coord_t              y_cnt;
	logic                line_seen;	// current line had de
	logic                vsync_d;

	// band match on the low byte, first band wins
	always_comb begin
		for (int i = 0; i < BAND_NUM; i++) begin
			band_hit[i] = (data_i[CHAN_W-1:0] >= band_min_i[i]) &&
				(data_i[CHAN_W-1:0] <= band_max_i[i]);
		end
		if (band_hit[0])
			class_color = COLOR_BAND0;
		else if (band_hit[1])
			class_color = COLOR_BAND1;
		else if (band_hit[2])
			class_color = COLOR_BAND2;
		else if (band_hit[3])
			class_color = COLOR_BAND3;
		else
			class_color = COLOR_NONE;
	end

	//////////////////////////////////////////////////
	// raster position
	//////////////////////////////////////////////////
	always_ff @(posedge pixel_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			vsync_d   <= 1'b0;
			x_cnt     <= '0;
			y_cnt     <= '0;
			line_seen <= 1'b0;
		end else begin
			vsync_d <= vsync_i;
			if (vsync_i && !vsync_d) begin	// new frame
				x_cnt     <= '0;
				y_cnt     <= '0;
				line_seen <= 1'b0;
			end else if (de_i) begin
				x_cnt     <= x_cnt + 1'b1;
				line_seen <= 1'b1;
			end else if (line_seen) begin
				// first blank cycle after an active line
				x_cnt     <= '0;
				y_cnt     <= y_cnt + 1'b1;
				line_seen <= 1'b0;
			end
		end
	end

	always_ff @(posedge pixel_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			out_o.vsync <= 1'b0;
			out_o.hsync <= 1'b0;
			out_o.de    <= 1'b0;
			out_o.hit   <= 1'b0;
		end else begin
			out_o.vsync <= vsync_i;
			out_o.hsync <= hsync_i;
			out_o.de    <= de_i;
			out_o.hit   <= band_hit[0];	// target flag in both modes
		end
	end

	always_ff @(posedge pixel_clk_i) begin
		out_o.data <= mode_i ? class_color : data_i;
		out_o.x    <= x_cnt;
		out_o.y    <= y_cnt;
	end

endmodule

//--- rtl/target_bbox.sv
`timescale 1ns/1ps

module target_bbox (
	input  logic                 pixel_clk_i,
	input  logic                 arst_n_i,
	pixel_if.snk                 in_i,
	output vision_pkg::coord_t   box_left_o,
	output vision_pkg::coord_t   box_right_o,
	output vision_pkg::coord_t   box_top_o,
	output vision_pkg::coord_t   box_bottom_o,
	output logic                 box_found_o
);
	import vision_pkg::*;

	coord_t min_x;
	coord_t max_x;
	coord_t min_y;
	coord_t max_y;
	logic   seen;			// at least one hit this frame
	logic   vsync_d;
	logic   frame_start;
	logic   target_px;

	assign frame_start = in_i.vsync && !vsync_d;
	assign target_px   = in_i.de && in_i.hit;

	always_ff @(posedge pixel_clk_i or negedge arst_n_i) begin
		if (!arst_n_i)
			vsync_d <= 1'b0;
		else
			vsync_d <= in_i.vsync;
	end

	//////////////////////////////////////////////////
	// running box of the current frame
	//////////////////////////////////////////////////
	always_ff @(posedge pixel_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			min_x <= '1;
			max_x <= '0;
			min_y <= '1;
			max_y <= '0;
			seen  <= 1'b0;
		end else if (frame_start) begin
			min_x <= '1;	// restart for the new frame
			max_x <= '0;
			min_y <= '1;
			max_y <= '0;
			seen  <= 1'b0;
		end else if (target_px) begin
			if (in_i.x < min_x)
				min_x <= in_i.x;
			if (in_i.x > max_x)
				max_x <= in_i.x;
			if (in_i.y < min_y)
				min_y <= in_i.y;
			if (in_i.y > max_y)
				max_y <= in_i.y;
			seen <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// result of the finished frame
	//////////////////////////////////////////////////
	always_ff @(posedge pixel_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			box_left_o   <= '0;
			box_right_o  <= '0;
			box_top_o    <= '0;
			box_bottom_o <= '0;
			box_found_o  <= 1'b0;
		end else if (frame_start) begin
			// empty frame reports a zero box
			box_left_o   <= seen ? min_x : '0;
			box_right_o  <= seen ? max_x : '0;
			box_top_o    <= seen ? min_y : '0;
			box_bottom_o <= seen ? max_y : '0;
			box_found_o  <= seen;
		end
	end

endmodule

//--- rtl/box_overlay.sv
`timescale 1ns/1ps

module box_overlay (
	input  logic                 pixel_clk_i,
	input  logic                 arst_n_i,
	pixel_if.snk                 in_i,
	input  vision_pkg::coord_t   box_left_i,
	input  vision_pkg::coord_t   box_right_i,
	input  vision_pkg::coord_t   box_top_i,
	input  vision_pkg::coord_t   box_bottom_i,
	input  logic                 box_found_i,
	pixel_if.src                 out_o
);
	import vision_pkg::*;

	logic in_cols;		// x within left..right
	logic in_rows;		// y within top..bottom
	logic on_border;
	logic draw;

	assign in_cols = (in_i.x >= box_left_i) && (in_i.x <= box_right_i);
	assign in_rows = (in_i.y >= box_top_i) && (in_i.y <= box_bottom_i);

	// vertical edges, then horizontal edges
	assign on_border = ((in_i.x == box_left_i || in_i.x == box_right_i) && in_rows) ||
		((in_i.y == box_top_i || in_i.y == box_bottom_i) && in_cols);

	assign draw = box_found_i && in_i.de && on_border;

	always_ff @(posedge pixel_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			out_o.vsync <= 1'b0;
			out_o.hsync <= 1'b0;
			out_o.de    <= 1'b0;
			out_o.hit   <= 1'b0;
		end else begin
			out_o.vsync <= in_i.vsync;
			out_o.hsync <= in_i.hsync;
			out_o.de    <= in_i.de;
			out_o.hit   <= in_i.hit;
		end
	end

	always_ff @(posedge pixel_clk_i) begin
		out_o.data <= draw ? COLOR_BOX : in_i.data;
		out_o.x    <= in_i.x;
		out_o.y    <= in_i.y;
	end

endmodule

//--- rtl/tmds_encoder.sv
`timescale 1ns/1ps

module tmds_encoder (
	input  logic                 pixel_clk_i,
	input  logic                 arst_n_i,
	input  logic                 de_i,
	input  vision_pkg::chan_t    video_i,
	input  logic [1:0]           ctrl_i,		// {c1, c0}
	output vision_pkg::tmds_t    tmds_o
);
	import vision_pkg::*;

	logic [3:0] n1_d;		// ones in the input byte
	logic [3:0] n1_q;		// ones in q_m[7:0]
	logic [3:0] n0_q;
	logic       use_xnor;
	logic [8:0] q_m;
	disp_t      bal_q;		// ones minus zeros of q_m[7:0]
	disp_t      disp_q;
	disp_t      disp_next;
	tmds_t      video_sym;
	tmds_t      ctrl_sym;

	//////////////////////////////////////////////////
	// stage 1, transition minimisation
	//////////////////////////////////////////////////
	always_comb begin
		n1_d     = 4'($countones(video_i));
		use_xnor = (n1_d > 4'd4) || (n1_d == 4'd4 && !video_i[0]);
		q_m[0]   = video_i[0];
		for (int i = 1; i < CHAN_W; i++) begin
			q_m[i] = use_xnor ? ~(q_m[i-1] ^ video_i[i]) : (q_m[i-1] ^ video_i[i]);
		end
		q_m[8] = !use_xnor;
	end

	//////////////////////////////////////////////////
	// stage 2, dc balance
	//////////////////////////////////////////////////
	always_comb begin
		n1_q  = 4'($countones(q_m[7:0]));
		n0_q  = 4'd8 - n1_q;
		bal_q = disp_t'(n1_q) - disp_t'(n0_q);
		if (disp_q == 0 || bal_q == 0) begin
			video_sym = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
			disp_next = q_m[8] ? disp_q + bal_q : disp_q - bal_q;
		end else if ((disp_q > 0 && bal_q > 0) || (disp_q < 0 && bal_q < 0)) begin
			// invert to pull the balance back
			video_sym = {1'b1, q_m[8], ~q_m[7:0]};
			disp_next = disp_q + (q_m[8] ? disp_t'(2) : disp_t'(0)) - bal_q;
		end else begin
			video_sym = {1'b0, q_m[8], q_m[7:0]};
			disp_next = disp_q - (q_m[8] ? disp_t'(0) : disp_t'(2)) + bal_q;
		end
	end

	always_comb begin
		case (ctrl_i)
			2'b00:   ctrl_sym = TMDS_CTRL_00;
			2'b01:   ctrl_sym = TMDS_CTRL_01;
			2'b10:   ctrl_sym = TMDS_CTRL_10;
			default: ctrl_sym = TMDS_CTRL_11;
		endcase
	end

	always_ff @(posedge pixel_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			tmds_o <= TMDS_CTRL_00;
			disp_q <= '0;
		end else if (de_i) begin
			tmds_o <= video_sym;
			disp_q <= disp_next;
		end else begin
			tmds_o <= ctrl_sym;
			disp_q <= '0;	// balance restarts after blanking
		end
	end

endmodule

//--- rtl/rgb2dvi.sv
`timescale 1ns/1ps

module rgb2dvi (
	input  logic                 pixel_clk_i,
	input  logic                 arst_n_i,
	input  logic                 vsync_i,
	input  logic                 hsync_i,
	input  logic                 de_i,
	input  logic                 mode_i,
	input  vision_pkg::rgb_t     data_i,		// [23:16] r, [15:8] g, [7:0] b
	input  vision_pkg::chan_t    y_min_i,		// band 0, target
	input  vision_pkg::chan_t    y_max_i,
	input  vision_pkg::chan_t    cb_min_i,		// band 1
	input  vision_pkg::chan_t    cb_max_i,
	input  vision_pkg::chan_t    cr_min_i,		// band 2
	input  vision_pkg::chan_t    cr_max_i,
	input  vision_pkg::chan_t    yellow_min_i,	// band 3
	input  vision_pkg::chan_t    yellow_max_i,
	input  logic [3:0]           bitflip_i,		// [3] clock lane, [2:0] data lanes
	output vision_pkg::coord_t   target_x_o,
	output vision_pkg::coord_t   target_y_o,
	output logic                 target_found_o,
	output vision_pkg::tmds_t    txc_o,
	output vision_pkg::tmds_t    txd0_o,
	output vision_pkg::tmds_t    txd1_o,
	output vision_pkg::tmds_t    txd2_o
);
	import vision_pkg::*;

	chan_t  band_min [BAND_NUM];
	chan_t  band_max [BAND_NUM];
	coord_t box_left;
	coord_t box_right;
	coord_t box_top;
	coord_t box_bottom;
	logic   box_found;
	tmds_t  tmds_0;
	tmds_t  tmds_1;
	tmds_t  tmds_2;

	pixel_if cls_bus ();
	pixel_if ovl_bus ();

	assign band_min = '{y_min_i, cb_min_i, cr_min_i, yellow_min_i};
	assign band_max = '{y_max_i, cb_max_i, cr_max_i, yellow_max_i};

	//////////////////////////////////////////////////
	// pixel stages
	//////////////////////////////////////////////////
	color_classifier i_color_classifier (
		.pixel_clk_i (pixel_clk_i),
		.arst_n_i    (arst_n_i),
		.vsync_i     (vsync_i),
		.hsync_i     (hsync_i),
		.de_i        (de_i),
		.mode_i      (mode_i),
		.data_i      (data_i),
		.band_min_i  (band_min),
		.band_max_i  (band_max),
		.out_o       (cls_bus)
	);

	target_bbox i_target_bbox (
		.pixel_clk_i  (pixel_clk_i),
		.arst_n_i     (arst_n_i),
		.in_i         (cls_bus),
		.box_left_o   (box_left),
		.box_right_o  (box_right),
		.box_top_o    (box_top),
		.box_bottom_o (box_bottom),
		.box_found_o  (box_found)
	);

	box_overlay i_box_overlay (
		.pixel_clk_i  (pixel_clk_i),
		.arst_n_i     (arst_n_i),
		.in_i         (cls_bus),
		.box_left_i   (box_left),
		.box_right_i  (box_right),
		.box_top_i    (box_top),
		.box_bottom_i (box_bottom),
		.box_found_i  (box_found),
		.out_o        (ovl_bus)
	);

	assign target_x_o     = box_left;
	assign target_y_o     = box_top;
	assign target_found_o = box_found;

	//////////////////////////////////////////////////
	// tmds channels
	//////////////////////////////////////////////////
	// blue carries the syncs
	tmds_encoder i_enc_0 (
		.pixel_clk_i (pixel_clk_i),
		.arst_n_i    (arst_n_i),
		.de_i        (ovl_bus.de),
		.video_i     (ovl_bus.data[CHAN_W-1:0]),
		.ctrl_i      ({ovl_bus.vsync, ovl_bus.hsync}),
		.tmds_o      (tmds_0)
	);

	tmds_encoder i_enc_1 (
		.pixel_clk_i (pixel_clk_i),
		.arst_n_i    (arst_n_i),
		.de_i        (ovl_bus.de),
		.video_i     (ovl_bus.data[2*CHAN_W-1:CHAN_W]),	// green
		.ctrl_i      (2'b00),
		.tmds_o      (tmds_1)
	);

	tmds_encoder i_enc_2 (
		.pixel_clk_i (pixel_clk_i),
		.arst_n_i    (arst_n_i),
		.de_i        (ovl_bus.de),
		.video_i     (ovl_bus.data[3*CHAN_W-1:2*CHAN_W]),	// red
		.ctrl_i      (2'b00),
		.tmds_o      (tmds_2)
	);

	// lane polarity swap
	assign txc_o  = bitflip_i[3] ? ~TMDS_CLK_PATTERN : TMDS_CLK_PATTERN;
	assign txd0_o = bitflip_i[0] ? ~tmds_0 : tmds_0;
	assign txd1_o = bitflip_i[1] ? ~tmds_1 : tmds_1;
	assign txd2_o = bitflip_i[2] ? ~tmds_2 : tmds_2;

endmodule

//--- testbench/tb_rgb2dvi.sv
`timescale 1ns/1ps

module tb_rgb2dvi;
	import vision_pkg::*;

	localparam int  N_ENTRY     = 4;
	localparam int  COLS        = 16;
	localparam int  ROWS        = 8;
	localparam int  V_BLANK     = 3;	// blank lines ahead of the active area
	localparam int  LINE_CYC    = 24;
	localparam int  HS_START    = 18;
	localparam int  HS_LEN      = 4;
	localparam int  RESET_CYC   = 16;
	localparam int  DRAIN_CYC   = 4;
	localparam int  FRAME_CYC   = LINE_CYC * (V_BLANK + ROWS);
	localparam real HALF_NS     = 20.0;
	localparam real WATCHDOG_NS = 2.0 * 2.0 * HALF_NS *
		(N_ENTRY * 2 * FRAME_CYC + RESET_CYC + DRAIN_CYC);
	localparam tmds_t CLK_WORD  = 10'b1111100000;

	typedef struct packed {
		logic            mode;
		logic [3:0]      flip;
		logic [3:0][7:0] bmin;		// [0] is band 0
		logic [3:0][7:0] bmax;
		logic            has_tgt;
		coord_t          tx0;
		coord_t          ty0;
		coord_t          tx1;
		coord_t          ty1;
		chan_t           tgt_low;
		logic            exp_found;
		coord_t          exp_x;
		coord_t          exp_y;
	} entry_t;

	typedef struct packed {
		logic   de;
		logic   vs;
		logic   hs;
		rgb_t   pix;
	} exp_t;

	typedef struct packed {
		logic   found;
		coord_t l;
		coord_t r;
		coord_t t;
		coord_t b;
	} box_t;

	logic       pixel_clk;
	logic       arst_n;
	logic       vsync;
	logic       hsync;
	logic       de;
	logic       mode;
	rgb_t       data;
	chan_t      band_min [BAND_NUM];
	chan_t      band_max [BAND_NUM];
	logic [3:0] bitflip;
	coord_t     target_x;
	coord_t     target_y;
	logic       target_found;
	tmds_t      txc;
	tmds_t      txd0;
	tmds_t      txd1;
	tmds_t      txd2;

	entry_t tbl [N_ENTRY];
	exp_t   exp_q [$];		// one entry per driven cycle
	box_t   rep_box;		// box drawn in the current frame
	box_t   last_box;		// box found in the frame just sent

	rgb2dvi i_rgb2dvi (
		.pixel_clk_i (pixel_clk), .arst_n_i (arst_n),
		.vsync_i (vsync), .hsync_i (hsync), .de_i (de), .mode_i (mode), .data_i (data),
		.y_min_i (band_min[0]), .y_max_i (band_max[0]),
		.cb_min_i (band_min[1]), .cb_max_i (band_max[1]),
		.cr_min_i (band_min[2]), .cr_max_i (band_max[2]),
		.yellow_min_i (band_min[3]), .yellow_max_i (band_max[3]),
		.bitflip_i (bitflip),
		.target_x_o (target_x), .target_y_o (target_y), .target_found_o (target_found),
		.txc_o (txc), .txd0_o (txd0), .txd1_o (txd1), .txd2_o (txd2)
	);

	always #(HALF_NS) pixel_clk = ~pixel_clk;

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////
	task automatic abort_run();
		$display("ERRORS FOUND");
		$fatal(1, "run stopped");
	endtask

	task automatic check_pixel(input string name, input rgb_t got, input rgb_t want);
		if (got !== want) begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, want);
			abort_run();
		end
	endtask

	task automatic check_coord(input string name, input coord_t got, input coord_t want);
		if (got !== want) begin
			$display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, want);
			abort_run();
		end
	endtask

	task automatic check_symbol(input string name, input tmds_t got, input tmds_t want);
		if (got !== want) begin
			$display("FAIL t=%0t %s got %b expected %b", $time, name, got, want);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("FAIL t=%0t %s got %b expected %b", $time, name, got, want);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////
	function automatic rgb_t band_color(input int b);
		case (b)
			0:       return 24'h7F0000;
			1:       return 24'h00FF00;
			2:       return 24'h0000FF;
			default: return 24'hFFFF00;
		endcase
	endfunction

	// first band holding the low byte wins
	function automatic rgb_t classify(input int e, input chan_t low);
		for (int b = 0; b < BAND_NUM; b++) begin
			if (low >= tbl[e].bmin[b] && low <= tbl[e].bmax[b])
				return band_color(b);
		end
		return 24'h000000;
	endfunction

	function automatic logic on_border(input coord_t x, input coord_t y);
		return ((x == rep_box.l || x == rep_box.r) && y >= rep_box.t && y <= rep_box.b) ||
			((y == rep_box.t || y == rep_box.b) && x >= rep_box.l && x <= rep_box.r);
	endfunction

	function automatic rgb_t make_pixel(input int e, input logic act, input coord_t x,
		input coord_t y);
		logic [31:0] rnd;
		rgb_t        pix;
		rnd = $urandom();
		pix = rnd[23:0];
		if (act && tbl[e].has_tgt && x >= tbl[e].tx0 && x <= tbl[e].tx1 &&
			y >= tbl[e].ty0 && y <= tbl[e].ty1)
			pix[7:0] = tbl[e].tgt_low;
		else if (pix[7:0] >= tbl[e].bmin[0] && pix[7:0] <= tbl[e].bmax[0])
			pix[7:0] = pix[7:0] ^ 8'h80;	// keep background out of band 0
		return pix;
	endfunction

	function automatic rgb_t expect_pixel(input int e, input rgb_t pix, input coord_t x,
		input coord_t y);
		if (rep_box.found && on_border(x, y))
			return 24'hFFFFFF;
		return tbl[e].mode ? classify(e, pix[7:0]) : pix;
	endfunction

	function automatic tmds_t ctrl_token(input logic [1:0] c);
		case (c)
			2'b00:   return 10'b1101010100;
			2'b01:   return 10'b0010101011;
			2'b10:   return 10'b0101010100;
			default: return 10'b1010101011;
		endcase
	endfunction

	// stateless dvi data decode
	function automatic chan_t decode_data(input tmds_t s);
		logic [7:0] d;
		chan_t      v;
		d    = s[9] ? ~s[7:0] : s[7:0];
		v[0] = d[0];
		for (int i = 1; i < 8; i++)
			v[i] = s[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
		return v;
	endfunction

	//////////////////////////////////////////////////
	// stimulus and checks
	//////////////////////////////////////////////////
	task automatic check_lanes(input exp_t item);
		tmds_t s0;
		tmds_t s1;
		tmds_t s2;
		s0 = bitflip[0] ? ~txd0 : txd0;		// undo the lane flip
		s1 = bitflip[1] ? ~txd1 : txd1;
		s2 = bitflip[2] ? ~txd2 : txd2;
		check_symbol("txc_o", txc, bitflip[3] ? ~CLK_WORD : CLK_WORD);
		if (item.de) begin
			check_pixel("decoded txd2_o/txd1_o/txd0_o",
				{decode_data(s2), decode_data(s1), decode_data(s0)}, item.pix);
		end else begin
			check_symbol("txd0_o", s0, ctrl_token({item.vs, item.hs}));
			check_symbol("txd1_o", s1, ctrl_token(2'b00));
			check_symbol("txd2_o", s2, ctrl_token(2'b00));
		end
	endtask

	task automatic check_idle();
		check_flag("target_found_o", target_found, 1'b0);
		check_coord("target_x_o", target_x, '0);
		check_coord("target_y_o", target_y, '0);
		check_symbol("txc_o", txc, CLK_WORD);
		check_symbol("txd0_o", txd0, ctrl_token(2'b00));
		check_symbol("txd1_o", txd1, ctrl_token(2'b00));
		check_symbol("txd2_o", txd2, ctrl_token(2'b00));
	endtask

	task automatic check_target();
		check_flag("target_found_o", target_found, rep_box.found);
		if (rep_box.found) begin
			check_coord("target_x_o", target_x, rep_box.l);
			check_coord("target_y_o", target_y, rep_box.t);
		end
	endtask

	// sample the lanes and then drive the next input on the same falling edge
	task automatic step(input logic vs, input logic hs, input logic act, input rgb_t pix,
		input rgb_t want);
		exp_t item;
		@(negedge pixel_clk);
		if (exp_q.size() == 3)
			check_lanes(exp_q.pop_front());	// pipeline is 3 cycles deep
		vsync = vs;
		hsync = hs;
		de    = act;
		data  = pix;
		item.de  = act;
		item.vs  = vs;
		item.hs  = hs;
		item.pix = want;
		exp_q.push_back(item);
	endtask

	task automatic drive_frame(input int e);
		logic   act;
		logic   vs;
		logic   hs;
		rgb_t   pix;
		coord_t x;
		coord_t y;
		rep_box = last_box;	// latched at this frame's vsync
		for (int ln = 0; ln < V_BLANK + ROWS; ln++) begin
			if (ln == V_BLANK)
				check_target();
			for (int c = 0; c < LINE_CYC; c++) begin
				act = (ln >= V_BLANK) && (c < COLS);
				vs  = (ln == 0);
				hs  = (c >= HS_START) && (c < HS_START + HS_LEN);
				x   = coord_t'(c);
				y   = coord_t'(ln - V_BLANK);
				pix = make_pixel(e, act, x, y);
				step(vs, hs, act, pix, expect_pixel(e, pix, x, y));
			end
		end
		last_box.found = tbl[e].exp_found;
		last_box.l     = tbl[e].exp_x;
		last_box.t     = tbl[e].exp_y;
		last_box.r     = tbl[e].tx1;
		last_box.b     = tbl[e].ty1;
	endtask

	// mode, flip, band min {3,2,1,0}, band max, target, rect x0 y0 x1 y1, low byte, expected box
	task automatic load_table();
		tbl[0] = '{1'b0, 4'b0000, 32'h60_40_30_10, 32'h6F_4F_3F_1F,
			1'b1, 12'd3, 12'd2, 12'd7, 12'd4, 8'h15, 1'b1, 12'd3, 12'd2};
		// target byte also falls in band 1
		tbl[1] = '{1'b1, 4'b0101, 32'h60_40_18_10, 32'h6F_4F_3F_1F,
			1'b1, 12'd10, 12'd5, 12'd14, 12'd6, 8'h1A, 1'b1, 12'd10, 12'd5};
		// overlapping bands for priority and no target
		tbl[2] = '{1'b1, 4'b1010, 32'hA0_80_20_40, 32'hFF_BF_9F_47,
			1'b0, 12'd0, 12'd0, 12'd0, 12'd0, 8'h00, 1'b0, 12'd0, 12'd0};
		tbl[3] = '{1'b0, 4'b1111, 32'h60_40_30_00, 32'h6F_4F_3F_07,
			1'b1, 12'd15, 12'd7, 12'd15, 12'd7, 8'h03, 1'b1, 12'd15, 12'd7};
	endtask

	initial begin
		pixel_clk = 1'b0;
		arst_n    = 1'b0;
		vsync     = 1'b0;
		hsync     = 1'b0;
		de        = 1'b0;
		mode      = 1'b0;
		data      = '0;
		bitflip   = '0;
		for (int i = 0; i < BAND_NUM; i++) begin
			band_min[i] = '0;
			band_max[i] = '0;
		end
		void'($urandom(32'he7d4_18e5));
		load_table();
		rep_box  = '0;
		last_box = '0;

		repeat (RESET_CYC) @(negedge pixel_clk);
		check_idle();	// still in reset
		arst_n = 1'b1;
		@(negedge pixel_clk);
		check_idle();

		for (int e = 0; e < N_ENTRY; e++) begin
			mode    = tbl[e].mode;
			bitflip = tbl[e].flip;
			for (int i = 0; i < BAND_NUM; i++) begin
				band_min[i] = tbl[e].bmin[i];
				band_max[i] = tbl[e].bmax[i];
			end
			drive_frame(e);
			drive_frame(e);		// second frame shows the first one's box
		end
		repeat (DRAIN_CYC) step(1'b0, 1'b0, 1'b0, '0, '0);
		$display("NO ERRORS");
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the stimulus did not finish in the expected time");
		abort_run();
	end

endmodule

//--- sources.f
rtl/vision_pkg.sv
rtl/pixel_if.sv
rtl/color_classifier.sv
rtl/target_bbox.sv
rtl/box_overlay.sv
rtl/tmds_encoder.sv
rtl/rgb2dvi.sv
testbench/tb_rgb2dvi.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_rgb2dvi with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_rgb2dvi -Mdir obj_dir -f sources.f
	@out="$$(./obj_dir/Vtb_rgb2dvi)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
